//--- hdl/qos_admit_pkg.sv
// qos admission types, class encoding and default sizing
package qos_admit_pkg;

    // request field widths
    typedef logic [3:0]  qos_t;
    typedef logic [6:0]  srcid_t;
    typedef logic [11:0] txnid_t;

    // pool class of a request, an entry or a grant
    typedef enum logic [1:0] {
        CLASS_NONE = 2'd0,
        CLASS_LOW  = 2'd1,
        CLASS_HIGH = 2'd2
    } qos_class_e;

    // qos at or above this value is high class
    localparam qos_t QOS_HIGH_MIN = 4'd8;

    // qos carried by a credit grant
    localparam qos_t GRANT_QOS_HIGH = 4'd15;
    localparam qos_t GRANT_QOS_LOW  = 4'd0;

    // decoded request fields
    typedef struct packed {
        srcid_t srcid;
        txnid_t txnid;
        qos_t   qos;
        logic   allow_retry;
    } qos_req_t;

    typedef struct packed {
        srcid_t     srcid;
        txnid_t     txnid;
        qos_t       qos;
        qos_class_e pcrd_class;
    } retry_ack_t;

    // no source id, any requester of the class may use it
    typedef struct packed {
        qos_t       qos;
        qos_class_e pcrd_class;
    } pcrd_grant_t;

    // default sizing
    localparam int DEF_HIGH_POOL    = 2;
    localparam int DEF_LOW_POOL     = 2;
    localparam int DEF_LOW2HIGH_MAX = 2;
    localparam int DEF_QUEUE_DEPTH  = 4;

endpackage

//--- hdl/resp_queue.sv
// synchronous fifo for outgoing retry acks and credit grants, consumer pops on valid
`timescale 1ns/100ps

module resp_queue #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    input  logic             pop,
    output logic             valid,
    output logic [WIDTH-1:0] data_out
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = count == CNT_W'(DEPTH);
    assign valid    = count != '0;
    assign do_pop   = pop & valid;
    // full queue takes a push only when the head leaves at the same edge
    assign do_push  = push & (~full | do_pop);
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) push && full |-> pop)
        else $error("push into full queue dropped");

    // stalled consumer sees a steady head
    assert property (@(posedge clk) disable iff (rst) valid && !pop |=> valid && $stable(data_out))
        else $error("queue head changed while not popped");

endmodule

//--- hdl/admission_ctrl.sv
// request classification, pool occupancy counters and allocate-or-retry decision
`timescale 1ns/100ps

module admission_ctrl
    import qos_admit_pkg::*;
#(
    parameter int HIGH_POOL = DEF_HIGH_POOL,
    parameter int LOW_POOL  = DEF_LOW_POOL
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  qos_req_t   req,
    input  logic       retire_valid,
    input  qos_class_e retire_class,
    input  qos_class_e grant_class,
    output logic       alloc_valid,
    output qos_req_t   alloc_req,
    output logic       dyn_alloc,
    output logic       static_alloc,
    output qos_class_e alloc_class,
    output logic       retry_push,
    output qos_class_e retry_class,
    output retry_ack_t retry_ack_data
);

    localparam int MAX_POOL = (HIGH_POOL > LOW_POOL) ? HIGH_POOL : LOW_POOL;
    localparam int CNT_W    = $clog2(MAX_POOL + 1);

    typedef logic [CNT_W-1:0] pool_cnt_t;

    pool_cnt_t  high_cnt;
    pool_cnt_t  low_cnt;
    pool_cnt_t  high_cnt_ns;
    pool_cnt_t  low_cnt_ns;
    logic       high_full;
    logic       low_full;
    logic       is_high;
    logic       req_dyn;
    logic       take_high;
    logic       take_low;
    logic       high_dec;
    logic       low_dec;
    qos_class_e req_class;

    function automatic pool_cnt_t cnt_next(pool_cnt_t cnt, logic inc, logic dec);
        if (inc && !dec) begin
            return cnt + 1'b1;
        end
        if (dec && !inc) begin
            return cnt - 1'b1;
        end
        return cnt;
    endfunction

    assign is_high = req.qos >= QOS_HIGH_MIN;
    assign req_dyn = req_valid & req.allow_retry;

    // high class borrows from the low pool, never the other way
    assign take_high = req_dyn & is_high & ~high_full;
    assign take_low  = req_dyn & ~take_high & ~low_full;

    assign dyn_alloc    = take_high | take_low;
    assign static_alloc = req_valid & ~req.allow_retry;
    assign alloc_valid  = dyn_alloc | static_alloc;
    assign alloc_req    = alloc_valid ? req : '0;
    assign retry_push   = req_dyn & ~dyn_alloc;

    always_comb begin
        req_class   = is_high ? CLASS_HIGH : CLASS_LOW;
        alloc_class = CLASS_NONE;
        retry_class = CLASS_NONE;
        if (take_high) begin
            alloc_class = CLASS_HIGH;
        end else if (take_low) begin
            alloc_class = CLASS_LOW;
        end
        if (retry_push) begin
            retry_class = req_class;
        end
    end

    always_comb begin
        retry_ack_data.srcid      = req.srcid;
        retry_ack_data.txnid      = req.txnid;
        retry_ack_data.qos        = req.qos;
        retry_ack_data.pcrd_class = req_class;
    end

    // a granted slot stays counted in its pool
    assign high_dec = retire_valid && grant_class == CLASS_NONE && retire_class == CLASS_HIGH;
    assign low_dec  = retire_valid && grant_class == CLASS_NONE && retire_class == CLASS_LOW;

    assign high_cnt_ns = cnt_next(high_cnt, take_high, high_dec);
    assign low_cnt_ns  = cnt_next(low_cnt, take_low, low_dec);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            high_cnt  <= '0;
            low_cnt   <= '0;
            high_full <= 1'b0;
            low_full  <= 1'b0;
        end else begin
            high_cnt  <= high_cnt_ns;
            low_cnt   <= low_cnt_ns;
            high_full <= high_cnt_ns == pool_cnt_t'(HIGH_POOL);
            low_full  <= low_cnt_ns == pool_cnt_t'(LOW_POOL);
        end
    end

    // retired entry class must agree with what this pool counted
    assert property (@(posedge clk) disable iff (rst)
        !(high_dec && high_cnt == '0) && !(low_dec && low_cnt == '0))
        else $error("pool counter underflow on retire");

endmodule

//--- hdl/tracker_entry_table.sv
// tracker entry state with valid, reserved and pool class per entry and lowest-index pick
`timescale 1ns/100ps

module tracker_entry_table
    import qos_admit_pkg::*;
#(
    parameter int  ENTRY_NUM = DEF_HIGH_POOL + DEF_LOW_POOL,
    localparam int IDX_W     = (ENTRY_NUM > 1) ? $clog2(ENTRY_NUM) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             dyn_alloc,
    input  logic             static_alloc,
    input  qos_class_e       alloc_class,
    input  logic             retire_valid,
    input  logic [IDX_W-1:0] retire_idx,
    input  qos_class_e       grant_class,
    output logic [IDX_W-1:0] alloc_idx,
    output qos_class_e       retire_class
);

    logic [ENTRY_NUM-1:0] entry_valid;
    logic [ENTRY_NUM-1:0] entry_rsvd;
    logic [ENTRY_NUM-1:0] free_vec;
    logic [ENTRY_NUM-1:0] rsvd_vec;
    logic [IDX_W-1:0]     free_idx;
    logic [IDX_W-1:0]     rsvd_idx;
    logic                 alloc_en;
    qos_class_e           pool_class [ENTRY_NUM];

    function automatic logic [IDX_W-1:0] lowest_set(logic [ENTRY_NUM-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // free for dynamic use, or held for a granted static request
    assign free_vec = ~entry_valid & ~entry_rsvd;
    assign rsvd_vec = ~entry_valid & entry_rsvd;

    assign free_idx = lowest_set(free_vec);
    assign rsvd_idx = lowest_set(rsvd_vec);

    assign alloc_en     = dyn_alloc | static_alloc;
    assign alloc_idx    = static_alloc ? rsvd_idx : free_idx;
    assign retire_class = pool_class[retire_idx];

    for (genvar i = 0; i < ENTRY_NUM; i++) begin : g_entry
        logic alloc_hit;
        logic retire_hit;

        assign alloc_hit  = alloc_en && alloc_idx == IDX_W'(i);
        assign retire_hit = retire_valid && retire_idx == IDX_W'(i);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                entry_valid[i] <= 1'b0;
                entry_rsvd[i]  <= 1'b0;
                pool_class[i]  <= CLASS_NONE;
            end else begin
                if (alloc_hit) begin
                    entry_valid[i] <= 1'b1;
                    entry_rsvd[i]  <= 1'b0;
                end else if (retire_hit) begin
                    entry_valid[i] <= 1'b0;
                    // granted slot is kept for the class that got the credit
                    entry_rsvd[i]  <= grant_class != CLASS_NONE;
                end
                // static reuse keeps the pool the slot was counted in
                if (alloc_hit && dyn_alloc) begin
                    pool_class[i] <= alloc_class;
                end
            end
        end
    end

    // pool counters in admission_ctrl must never promise more than the table holds
    assert property (@(posedge clk) disable iff (rst) dyn_alloc |-> |free_vec)
        else $error("dynamic allocation with no free entry");

    assert property (@(posedge clk) disable iff (rst) static_alloc |-> |rsvd_vec)
        else $error("static allocation with no reserved entry");

endmodule

//--- hdl/credit_grant_arbiter.sv
// pending retry counts, low class starvation counter and credit grant choice on retire
`timescale 1ns/100ps

module credit_grant_arbiter
    import qos_admit_pkg::*;
#(
    parameter int LOW2HIGH_MAX = DEF_LOW2HIGH_MAX
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        retry_push,
    input  qos_class_e  retry_class,
    input  logic        retire_valid,
    input  qos_class_e  retire_class,
    output qos_class_e  grant_class,
    output logic        grant_push,
    output pcrd_grant_t grant_data
);

    localparam int PEND_W = 8;
    localparam int WAIT_W = (LOW2HIGH_MAX > 0) ? $clog2(LOW2HIGH_MAX + 1) : 1;

    typedef logic [PEND_W-1:0] pend_t;

    pend_t             high_pend;
    pend_t             low_pend;
    logic [WAIT_W-1:0] wait_cnt;
    logic              high_nz;
    logic              low_nz;
    logic              wait_inc;
    logic              wait_clr;
    logic              high_inc;
    logic              low_inc;
    logic              high_dec;
    logic              low_dec;

    function automatic pend_t pend_next(pend_t cnt, logic inc, logic dec);
        if (inc && !dec) begin
            return cnt + 1'b1;
        end
        if (dec && !inc) begin
            return cnt - 1'b1;
        end
        return cnt;
    endfunction

    assign high_nz = high_pend != '0;
    assign low_nz  = low_pend != '0;

    always_comb begin
        grant_class = CLASS_NONE;
        wait_inc    = 1'b0;
        wait_clr    = 1'b0;
        if (retire_valid && retire_class == CLASS_HIGH) begin
            if (high_nz) begin
                grant_class = CLASS_HIGH;
            end
        end else if (retire_valid && retire_class == CLASS_LOW) begin
            // low wins once it has lost often enough
            if (low_nz && (wait_cnt >= WAIT_W'(LOW2HIGH_MAX) || !high_nz)) begin
                grant_class = CLASS_LOW;
                wait_clr    = 1'b1;
            end else if (high_nz) begin
                grant_class = CLASS_HIGH;
                wait_inc    = low_nz;
            end
        end
    end

    assign grant_push            = grant_class != CLASS_NONE;
    assign grant_data.qos        = (grant_class == CLASS_HIGH) ? GRANT_QOS_HIGH : GRANT_QOS_LOW;
    assign grant_data.pcrd_class = grant_class;

    assign high_inc = retry_push && retry_class == CLASS_HIGH;
    assign low_inc  = retry_push && retry_class == CLASS_LOW;
    assign high_dec = grant_class == CLASS_HIGH;
    assign low_dec  = grant_class == CLASS_LOW;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            high_pend <= '0;
            low_pend  <= '0;
            wait_cnt  <= '0;
        end else begin
            high_pend <= pend_next(high_pend, high_inc, high_dec);
            low_pend  <= pend_next(low_pend, low_inc, low_dec);
            if (wait_clr) begin
                wait_cnt <= '0;
            end else if (wait_inc && wait_cnt != WAIT_W'(LOW2HIGH_MAX)) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    // outstanding retries must fit the pending counters
    assert property (@(posedge clk) disable iff (rst)
        !(high_inc && !high_dec && high_pend == '1)
        && !(low_inc && !low_dec && low_pend == '1))
        else $error("pending retry count overflow");

endmodule

//--- hdl/qos_admit_top.sv
// qos admission top, joins admission control, entry table, grant arbiter and response queues
`timescale 1ns/100ps

module qos_admit_top
    import qos_admit_pkg::*;
#(
    parameter int  HIGH_POOL    = DEF_HIGH_POOL,
    parameter int  LOW_POOL     = DEF_LOW_POOL,
    parameter int  LOW2HIGH_MAX = DEF_LOW2HIGH_MAX,
    parameter int  QUEUE_DEPTH  = DEF_QUEUE_DEPTH,
    localparam int ENTRY_NUM    = HIGH_POOL + LOW_POOL,
    localparam int IDX_W        = (ENTRY_NUM > 1) ? $clog2(ENTRY_NUM) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    input  qos_req_t         req,
    input  logic             retire_valid,
    input  logic [IDX_W-1:0] retire_idx,
    input  logic             retry_ack_pop,
    input  logic             grant_pop,
    output logic             alloc_valid,
    output logic [IDX_W-1:0] alloc_idx,
    output qos_req_t         alloc_req,
    output logic             retry_ack_valid,
    output retry_ack_t       retry_ack,
    output logic             grant_valid,
    output pcrd_grant_t      grant
);

    logic        dyn_alloc;
    logic        static_alloc;
    qos_class_e  alloc_class;
    qos_class_e  retire_class;
    logic        retry_push;
    qos_class_e  retry_class;
    retry_ack_t  retry_ack_data;
    qos_class_e  grant_class;
    logic        grant_push;
    pcrd_grant_t grant_data;

    admission_ctrl #(
        .HIGH_POOL (HIGH_POOL),
        .LOW_POOL  (LOW_POOL)
    ) u_admission_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .retire_valid   (retire_valid),
        .retire_class   (retire_class),
        .grant_class    (grant_class),
        .alloc_valid    (alloc_valid),
        .alloc_req      (alloc_req),
        .dyn_alloc      (dyn_alloc),
        .static_alloc   (static_alloc),
        .alloc_class    (alloc_class),
        .retry_push     (retry_push),
        .retry_class    (retry_class),
        .retry_ack_data (retry_ack_data)
    );

    tracker_entry_table #(
        .ENTRY_NUM (ENTRY_NUM)
    ) u_tracker_entry_table (
        .clk          (clk),
        .rst          (rst),
        .dyn_alloc    (dyn_alloc),
        .static_alloc (static_alloc),
        .alloc_class  (alloc_class),
        .retire_valid (retire_valid),
        .retire_idx   (retire_idx),
        .grant_class  (grant_class),
        .alloc_idx    (alloc_idx),
        .retire_class (retire_class)
    );

    credit_grant_arbiter #(
        .LOW2HIGH_MAX (LOW2HIGH_MAX)
    ) u_credit_grant_arbiter (
        .clk          (clk),
        .rst          (rst),
        .retry_push   (retry_push),
        .retry_class  (retry_class),
        .retire_valid (retire_valid),
        .retire_class (retire_class),
        .grant_class  (grant_class),
        .grant_push   (grant_push),
        .grant_data   (grant_data)
    );

    resp_queue #(
        .WIDTH ($bits(retry_ack_t)),
        .DEPTH (QUEUE_DEPTH)
    ) u_retry_ack_q (
        .clk      (clk),
        .rst      (rst),
        .push     (retry_push),
        .data_in  (retry_ack_data),
        .pop      (retry_ack_pop),
        .valid    (retry_ack_valid),
        .data_out (retry_ack)
    );

    resp_queue #(
        .WIDTH ($bits(pcrd_grant_t)),
        .DEPTH (QUEUE_DEPTH)
    ) u_grant_q (
        .clk      (clk),
        .rst      (rst),
        .push     (grant_push),
        .data_in  (grant_data),
        .pop      (grant_pop),
        .valid    (grant_valid),
        .data_out (grant)
    );

endmodule

//--- bench/tb_qos_admit.sv
// testbench for the qos admission block, table of requests and retires checked against a pool model
`timescale 1ns/100ps

module tb_qos_admit
    import qos_admit_pkg::*;
();

    localparam int HIGH_POOL    = 2;
    localparam int LOW_POOL     = 2;
    localparam int LOW2HIGH_MAX = 2;
    localparam int RESET_CYCLES = 16;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_REQ,
        OP_RET,
        OP_PACK,
        OP_PGNT
    } op_e;

    // one table row, stimulus then expected outcome
    typedef struct packed {
        op_e        op;
        qos_t       qos;
        logic       retry;
        logic [1:0] idx;
        logic       e_ok;
        logic [1:0] e_idx;
        qos_class_e e_cls;
    } row_t;

    logic        clk;
    logic        rst;
    logic        req_valid;
    qos_req_t    req;
    logic        retire_valid;
    logic [1:0]  retire_idx;
    logic        retry_ack_pop;
    logic        grant_pop;
    logic        alloc_valid;
    logic [1:0]  alloc_idx;
    qos_req_t    alloc_req;
    logic        retry_ack_valid;
    retry_ack_t  retry_ack;
    logic        grant_valid;
    pcrd_grant_t grant;

    row_t        rows[$];
    retry_ack_t  exp_acks[$];
    pcrd_grant_t exp_grants[$];
    integer      seed = 32'h3ce3;
    int          cycle_cnt = 0;
    int          cur_row = 0;
    int          row_errs = 0;
    int          errors = 0;
    int          checks = 0;

    // reference model state
    int          h_cnt = 0;
    int          l_cnt = 0;
    int          h_pend = 0;
    int          l_pend = 0;
    int          wait_cnt = 0;
    logic [3:0]  ent_v = '0;
    logic [3:0]  ent_r = '0;
    qos_class_e  ent_c [4];

    qos_admit_top #(
        .HIGH_POOL    (HIGH_POOL),
        .LOW_POOL     (LOW_POOL),
        .LOW2HIGH_MAX (LOW2HIGH_MAX),
        .QUEUE_DEPTH  (4)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req             (req),
        .retire_valid    (retire_valid),
        .retire_idx      (retire_idx),
        .retry_ack_pop   (retry_ack_pop),
        .grant_pop       (grant_pop),
        .alloc_valid     (alloc_valid),
        .alloc_idx       (alloc_idx),
        .alloc_req       (alloc_req),
        .retry_ack_valid (retry_ack_valid),
        .retry_ack       (retry_ack),
        .grant_valid     (grant_valid),
        .grant           (grant)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > RESET_CYCLES + 8 * rows.size()) begin
            $display("timeout after %0d cycles, the row loop did not finish", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    task automatic add_row(op_e op, int qos, logic retry, int idx, logic ok, int e_idx,
                           qos_class_e cls);
        row_t r;
        r.op    = op;
        r.qos   = qos_t'(qos);
        r.retry = retry;
        r.idx   = 2'(idx);
        r.e_ok  = ok;
        r.e_idx = 2'(e_idx);
        r.e_cls = cls;
        rows.push_back(r);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR row %0d: %s got %h expected %h", cur_row, name, got, exp);
            row_errs++;
        end
    endtask

    function automatic logic [1:0] first_set(logic [3:0] v);
        for (int k = 0; k < 4; k++) begin
            if (v[k]) begin
                return 2'(k);
            end
        end
        return 2'd0;
    endfunction

    task automatic model_step(input row_t r, output logic ok, output logic [1:0] idx,
                              output qos_class_e cls);
        qos_class_e pool;
        ok   = 1'b0;
        idx  = 2'd0;
        cls  = CLASS_NONE;
        pool = CLASS_NONE;
        if (r.op == OP_REQ && !r.retry) begin
            ok = 1'b1;
            idx = first_set(~ent_v & ent_r);
            ent_v[idx] = 1'b1;
            ent_r[idx] = 1'b0;
        end else if (r.op == OP_REQ) begin
            if (r.qos >= QOS_HIGH_MIN && h_cnt < HIGH_POOL) begin
                pool = CLASS_HIGH;
            end else if (l_cnt < LOW_POOL) begin
                pool = CLASS_LOW;
            end
            if (pool == CLASS_NONE && r.qos >= QOS_HIGH_MIN) begin
                h_pend++;
            end else if (pool == CLASS_NONE) begin
                l_pend++;
            end else begin
                ok = 1'b1;
                idx = first_set(~ent_v & ~ent_r);
                ent_v[idx] = 1'b1;
                ent_c[idx] = pool;
                if (pool == CLASS_HIGH) h_cnt++;
                else l_cnt++;
            end
        end else if (r.op == OP_RET) begin
            pool = ent_c[r.idx];
            if (pool == CLASS_HIGH) begin
                if (h_pend > 0) cls = CLASS_HIGH;
            end else if (l_pend > 0 && (wait_cnt >= LOW2HIGH_MAX || h_pend == 0)) begin
                cls = CLASS_LOW;
                wait_cnt = 0;
            end else if (h_pend > 0) begin
                cls = CLASS_HIGH;
                if (l_pend > 0 && wait_cnt < LOW2HIGH_MAX) wait_cnt++;
            end
            ok = cls != CLASS_NONE;
            if (cls == CLASS_HIGH) h_pend--;
            else if (cls == CLASS_LOW) l_pend--;
            else if (pool == CLASS_HIGH) h_cnt--;
            else l_cnt--;
            ent_v[r.idx] = 1'b0;
            ent_r[r.idx] = ok;
        end
    endtask

    task automatic build_table();
        // fill both pools, the third high request borrows a low entry
        add_row(OP_REQ, 12, 1, 0, 1, 0, CLASS_NONE);
        add_row(OP_REQ,  9, 1, 0, 1, 1, CLASS_NONE);
        add_row(OP_REQ, 15, 1, 0, 1, 2, CLASS_NONE);
        add_row(OP_REQ,  2, 1, 0, 1, 3, CLASS_NONE);
        // nothing pending, slot goes straight back to the pool
        add_row(OP_RET,  0, 0, 3, 0, 0, CLASS_NONE);
        add_row(OP_REQ,  5, 1, 0, 1, 3, CLASS_NONE);
        add_row(OP_REQ, 10, 1, 0, 0, 0, CLASS_NONE);
        add_row(OP_REQ,  3, 1, 0, 0, 0, CLASS_NONE);
        add_row(OP_PACK, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_PACK, 0, 0, 0, 0, 0, CLASS_NONE);
        // high grant, then static reuse of the same entry
        add_row(OP_RET,  0, 0, 0, 1, 0, CLASS_HIGH);
        add_row(OP_PGNT, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_REQ, 10, 0, 0, 1, 0, CLASS_NONE);
        // low waits two losses before it wins
        add_row(OP_REQ, 14, 1, 0, 0, 0, CLASS_NONE);
        add_row(OP_REQ, 11, 1, 0, 0, 0, CLASS_NONE);
        add_row(OP_REQ,  8, 1, 0, 0, 0, CLASS_NONE);
        add_row(OP_RET,  0, 0, 2, 1, 0, CLASS_HIGH);
        add_row(OP_REQ, 13, 0, 0, 1, 2, CLASS_NONE);
        add_row(OP_RET,  0, 0, 3, 1, 0, CLASS_HIGH);
        add_row(OP_REQ,  9, 0, 0, 1, 3, CLASS_NONE);
        add_row(OP_RET,  0, 0, 2, 1, 0, CLASS_LOW);
        add_row(OP_REQ,  4, 0, 0, 1, 2, CLASS_NONE);
        // queue heads held, then drained
        add_row(OP_IDLE, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_PACK, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_PACK, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_PACK, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_PGNT, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_PGNT, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_PGNT, 0, 0, 0, 0, 0, CLASS_NONE);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, CLASS_NONE);
    endtask

    initial begin
        row_t        r;
        qos_req_t    cur_req;
        retry_ack_t  exp_a;
        pcrd_grant_t exp_g;
        logic        m_ok;
        logic [1:0]  m_idx;
        qos_class_e  m_cls;
        rst           = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        retire_valid  = 1'b0;
        retire_idx    = '0;
        retry_ack_pop = 1'b0;
        grant_pop     = 1'b0;
        foreach (ent_c[k]) ent_c[k] = CLASS_NONE;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            cur_row = i;
            row_errs = 0;
            cur_req.srcid       = srcid_t'($random(seed));
            cur_req.txnid       = txnid_t'($random(seed));
            cur_req.qos         = r.qos;
            cur_req.allow_retry = r.retry;
            @(posedge clk);
            req_valid     <= r.op == OP_REQ;
            req           <= cur_req;
            retire_valid  <= r.op == OP_RET;
            retire_idx    <= r.idx;
            retry_ack_pop <= r.op == OP_PACK;
            grant_pop     <= r.op == OP_PGNT;
            model_step(r, m_ok, m_idx, m_cls);
            if ({m_ok, m_idx, m_cls} !== {r.e_ok, r.e_idx, r.e_cls}) begin
                $display("row %0d: table expectation differs from the reference model", i);
                row_errs++;
            end
            @(negedge clk);
            compare("alloc_valid", alloc_valid, r.op == OP_REQ && r.e_ok);
            if (r.op == OP_REQ && r.e_ok) begin
                compare("alloc_idx", alloc_idx, r.e_idx);
                compare("alloc_req", alloc_req, cur_req);
            end
            compare("retry_ack_valid", retry_ack_valid, exp_acks.size() != 0);
            if (exp_acks.size() != 0) compare("retry_ack", retry_ack, exp_acks[0]);
            compare("grant_valid", grant_valid, exp_grants.size() != 0);
            if (exp_grants.size() != 0) compare("grant", grant, exp_grants[0]);
            // pushes and pops land at the next edge
            if (r.op == OP_REQ && !r.e_ok) begin
                exp_a.srcid      = cur_req.srcid;
                exp_a.txnid      = cur_req.txnid;
                exp_a.qos        = cur_req.qos;
                exp_a.pcrd_class = (cur_req.qos >= QOS_HIGH_MIN) ? CLASS_HIGH : CLASS_LOW;
                exp_acks.push_back(exp_a);
            end
            if (r.op == OP_RET && r.e_ok) begin
                exp_g.qos        = (r.e_cls == CLASS_HIGH) ? 4'd15 : 4'd0;
                exp_g.pcrd_class = r.e_cls;
                exp_grants.push_back(exp_g);
            end
            if (r.op == OP_PACK && exp_acks.size() != 0) void'(exp_acks.pop_front());
            if (r.op == OP_PGNT && exp_grants.size() != 0) void'(exp_grants.pop_front());
            $display("row %0d %s: %s", i, r.op.name(), (row_errs != 0) ? "mismatch" : "ok");
            errors += row_errs;
        end
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb.f
hdl/qos_admit_pkg.sv
hdl/resp_queue.sv
hdl/admission_ctrl.sv
hdl/tracker_entry_table.sv
hdl/credit_grant_arbiter.sv
hdl/qos_admit_top.sv
bench/tb_qos_admit.sv
